//--- vlog.f
design/trace_pkg.sv
design/trace_stage.sv
design/rvi_decode.sv
design/rvc_decode.sv
design/instr_classify.sv
design/retire_tracer.sv
verif/retire_tracer_props.sv
verif/tb_retire_tracer.sv

//--- Bender.yml
package:
  name: retire_tracer

sources:
  # design
  - files:
      - design/trace_pkg.sv
      - design/trace_stage.sv
      - design/rvi_decode.sv
      - design/rvc_decode.sv
      - design/instr_classify.sv
      - design/retire_tracer.sv
  # verif
  - target: simulation
    files:
      - verif/retire_tracer_props.sv
      - verif/tb_retire_tracer.sv

//--- verif/tb_retire_tracer.sv
// ----------------------------------------------------------------------
// Self-checking with a decode model. Latency is only checked in tests
// that hold trace_ready_i high.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_retire_tracer;
    import trace_pkg::*;

    localparam int MAX_WAIT = 200;

    logic       s_clk_i;
    logic       rst_n_i;
    logic       retire_valid_i;
    logic       retire_ready_o;
    retire_s    retire_i;
    logic       trace_valid_o;
    logic       trace_ready_i;
    trace_rec_s trace_o;

    integer     seed;
    int         cyc = 0;
    int         errors = 0;
    int         checks = 0;
    int         tests = 0;
    bit         bp_on;
    bit         check_latency;
    bit         timed_out;
    trace_rec_s exp_q[$];
    int         acc_q[$];

    retire_tracer DUT (.*);

    initial begin
        s_clk_i = 1'b0;
        forever #50 s_clk_i = ~s_clk_i;
    end

    always @(posedge s_clk_i) cyc <= cyc + 1;

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERR %s got %0h exp %0h", name, got, want);
        end
    endtask

    task automatic report_timeout(input string why);
        errors++;
        timed_out = 1'b1;
        $display("%s", why);
    endtask

    // Major opcodes visited in turn. The last entry is an unassigned opcode.
    function automatic logic [4:0] opcode_for(input int idx);
        case (idx % 12)
            0:       return OPC_LUI;
            1:       return OPC_AUIPC;
            2:       return OPC_JAL;
            3:       return OPC_JALR;
            4:       return OPC_BRANCH;
            5:       return OPC_LOAD;
            6:       return OPC_STORE;
            7:       return OPC_OPIMM;
            8:       return OPC_OP;
            9:       return OPC_FENCE;
            10:      return OPC_SYSTEM;
            default: return 5'b10110;
        endcase
    endfunction

    // Expected class and registers, taken from the decode rules.
    function automatic instr_info_s model_info(input logic [31:0] ins);
        logic [3:0]  t;
        logic [4:0]  s1, s2, d;
        logic [4:0]  c_hi, c_lo, f_rd, f_rs2;
        logic        u1, u2, ud, sys_rw;
        instr_info_s info;
        c_hi   = 5'd8 + ins[9:7];
        c_lo   = 5'd8 + ins[4:2];
        f_rd   = ins[11:7];
        f_rs2  = ins[6:2];
        s1     = ins[19:15];
        s2     = ins[24:20];
        d      = ins[11:7];
        sys_rw = (s1 != 5'd0) || (d != 5'd0);
        if (ins[1:0] == 2'b11) begin
            case (ins[6:2])
                OPC_LUI, OPC_AUIPC: {t, u1, u2, ud} = {BASE, 3'b001};
                OPC_JAL:    {t, u1, u2, ud} = {JAL, 3'b001};
                OPC_JALR:   {t, u1, u2, ud} = {JALR, 3'b101};
                OPC_BRANCH: {t, u1, u2, ud} = {BRANCH, 3'b110};
                OPC_LOAD:   {t, u1, u2, ud} = {LOAD, 3'b101};
                OPC_STORE:  {t, u1, u2, ud} = {STORE, 3'b110};
                OPC_OPIMM:  {t, u1, u2, ud} = {BASE, 3'b101};
                OPC_OP:     {t, u1, u2, ud} = {(ins[25] ? MEXT : BASE), 3'b111};
                OPC_FENCE:  {t, u1, u2, ud} = {CSR, 3'b000};
                OPC_SYSTEM: {t, u1, u2, ud} = {CSR, sys_rw & ~ins[14], 1'b0, sys_rw};
                default:    {t, u1, u2, ud} = {BASE, 3'b000};
            endcase
        end else begin
            case ({ins[1:0], ins[15:13]})
                5'b00_000: {t, s1, s2, d, u1, u2, ud} = {BASE, REG_SP, 5'd0, c_lo, 3'b101};
                5'b00_010: {t, s1, s2, d, u1, u2, ud} = {LOAD, c_hi, 5'd0, c_lo, 3'b101};
                5'b00_110: {t, s1, s2, d, u1, u2, ud} = {STORE, c_hi, c_lo, 5'd0, 3'b110};
                5'b01_000: {t, s1, s2, d, u1, u2, ud} = {BASE, f_rd, 5'd0, f_rd, 3'b101};
                5'b01_001: {t, s1, s2, d, u1, u2, ud} = {JAL, 10'd0, REG_RA, 3'b001};
                5'b01_010: {t, s1, s2, d, u1, u2, ud} = {BASE, 10'd0, f_rd, 3'b001};
                5'b01_011: {t, s1, s2, d, u1, u2, ud} =
                    {BASE, REG_SP, 5'd0, f_rd, (f_rd == REG_SP), 2'b01};
                5'b01_100: {t, s1, s2, d, u1, u2, ud} =
                    {BASE, c_hi, c_lo, c_hi, 1'b1, (ins[11:10] == 2'b11), 1'b1};
                5'b01_101: {t, s1, s2, d, u1, u2, ud} = {JAL, 15'd0, 3'b001};
                5'b01_110, 5'b01_111: {t, s1, s2, d, u1, u2, ud} = {BRANCH, c_hi, 10'd0, 3'b100};
                5'b10_000: {t, s1, s2, d, u1, u2, ud} = {BASE, f_rd, 5'd0, f_rd, 3'b101};
                5'b10_010: {t, s1, s2, d, u1, u2, ud} = {LOAD, REG_SP, 5'd0, f_rd, 3'b101};
                5'b10_110: {t, s1, s2, d, u1, u2, ud} = {STORE, REG_SP, f_rs2, 5'd0, 3'b110};
                5'b10_100: begin
                    if (ins[12] && ins[11:2] == 10'd0)
                        {t, s1, s2, d, u1, u2, ud} = {CSR, 15'd0, 3'b000};
                    else if (f_rs2 != 5'd0)
                        {t, s1, s2, d, u1, u2, ud} = {BASE, f_rd, f_rs2, f_rd, ins[12], 2'b11};
                    else
                        {t, s1, s2, d, u1, u2, ud} =
                            {JALR, f_rd, 5'd0, (ins[12] ? REG_RA : 5'd0), 3'b101};
                end
                default: {t, s1, s2, d, u1, u2, ud} = {BASE, 15'd0, 3'b000};
            endcase
        end
        info.itype           = itype_e'(t);
        info.source.rs1      = u1 ? s1 : 5'd0;
        info.source.rs2      = u2 ? s2 : 5'd0;
        info.source.rs1_used = u1;
        info.source.rs2_used = u2;
        info.dest.rd         = ud ? d : 5'd0;
        info.dest.rd_used    = ud;
        return info;
    endfunction

    task automatic compare_record(input trace_rec_s want);
        check_value("trace_o.retire.pc", trace_o.retire.pc, want.retire.pc);
        check_value("trace_o.retire.instr", trace_o.retire.instr, want.retire.instr);
        check_value("trace_o.rvc", trace_o.rvc, want.rvc);
        check_value("trace_o.info.itype", trace_o.info.itype, want.info.itype);
        check_value("trace_o.info.source.rs1", trace_o.info.source.rs1, want.info.source.rs1);
        check_value("trace_o.info.source.rs2", trace_o.info.source.rs2, want.info.source.rs2);
        check_value("trace_o.info.source.rs1_used", trace_o.info.source.rs1_used,
                    want.info.source.rs1_used);
        check_value("trace_o.info.source.rs2_used", trace_o.info.source.rs2_used,
                    want.info.source.rs2_used);
        check_value("trace_o.info.dest.rd", trace_o.info.dest.rd, want.info.dest.rd);
        check_value("trace_o.info.dest.rd_used", trace_o.info.dest.rd_used,
                    want.info.dest.rd_used);
    endtask

    // Sampling mid-cycle sees both handshakes settled for the coming edge.
    always @(negedge s_clk_i) begin
        trace_rec_s rec;
        int         acc;
        if (rst_n_i) begin
            check_value("retire_ready_o", retire_ready_o, (exp_q.size() < 2) || trace_ready_i);
            if (trace_valid_o && exp_q.size() == 0) begin
                errors++;
                $display("trace_valid_o is high with no retire item in flight");
            end else if (trace_valid_o && trace_ready_i) begin
                rec = exp_q.pop_front();
                acc = acc_q.pop_front();
                compare_record(rec);
                if (check_latency)
                    check_value("trace_valid_o latency", cyc - acc, 2);
            end
            if (retire_valid_i && retire_ready_o) begin
                rec.retire = retire_i;
                rec.info   = model_info(retire_i.instr);
                rec.rvc    = (retire_i.instr[1:0] != 2'b11);
                exp_q.push_back(rec);
                acc_q.push_back(cyc);
            end
        end
    end

    task automatic next_cycle();
        logic [31:0] r;
        @(posedge s_clk_i);
        #10;
        r = $random(seed);
        trace_ready_i = bp_on ? r[0] : 1'b1;
    endtask

    task automatic gen_item(input int mode, input int idx, output retire_s item);
        logic [31:0] r;
        r = $random(seed);
        item.pc = $random(seed);
        item.pc[0] = 1'b0;
        item.instr = $random(seed);
        if (mode == 0 || (mode == 2 && r[31])) begin
            item.instr[1:0] = 2'b11;
            item.instr[6:2] = opcode_for(idx);
            if (r[1]) begin
                item.instr[19:15] = 5'd0;
                item.instr[11:7]  = 5'd0;
            end
        end else begin
            item.instr[1:0] = (r[3:2] == 2'b11) ? 2'b01 : r[3:2];
            if (r[4])
                item.instr[6:2] = 5'd0;
            if (r[4] && r[5])
                item.instr[11:7] = 5'd0;
            if (r[7:6] == 2'b00)
                item.instr[11:7] = REG_SP;
        end
    endtask

    task automatic send_item(input retire_s item);
        int waited;
        bit taken;
        retire_i       = item;
        retire_valid_i = 1'b1;
        taken          = 1'b0;
        waited         = 0;
        while (!taken && !timed_out) begin
            @(negedge s_clk_i);
            taken = retire_ready_o;
            next_cycle();
            waited++;
            if (!taken && waited > MAX_WAIT)
                report_timeout("Timed out waiting for retire_ready_o to accept an item.");
        end
        retire_valid_i = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited <= MAX_WAIT) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0)
            report_timeout("Timed out waiting for the trace output to drain.");
    endtask

    task automatic run_test(input string name, input int n, input int mode, input bit bp);
        retire_s     item;
        logic [31:0] r;
        int          err_start;
        if (timed_out)
            return;
        err_start     = errors;
        bp_on         = bp;
        check_latency = !bp;
        for (int i = 0; i < n && !timed_out; i++) begin
            gen_item(mode, i, item);
            send_item(item);
            r = $random(seed);
            if (bp && r[0])
                next_cycle();
        end
        for (int i = 0; i < 4; i++)
            next_cycle();
        drain();
        tests++;
        $display("test %s done: %0d items, %0d errors", name, n, errors - err_start);
    endtask

    initial begin
        seed           = 32'h37e2ea25;
        rst_n_i        = 1'b0;
        retire_valid_i = 1'b0;
        retire_i       = '0;
        trace_ready_i  = 1'b1;
        bp_on          = 1'b0;
        check_latency  = 1'b0;
        timed_out      = 1'b0;
        repeat (4) @(posedge s_clk_i);
        #10;
        rst_n_i = 1'b1;
        check_value("trace_valid_o", trace_valid_o, 1'b0);
        run_test("reset", 0, 0, 1'b0);
        run_test("rvi_classes", 144, 0, 1'b0);
        run_test("rvc_classes", 240, 1, 1'b0);
        run_test("stream", 100, 2, 1'b0);
        run_test("back_pressure", 300, 2, 1'b1);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- verif/retire_tracer_props.sv
// ----------------------------------------------------------------------
// Bound into retire_tracer. Both ports must hold a pending item stable.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module retire_tracer_props (
    input logic                  s_clk_i,
    input logic                  rst_n_i,
    input logic                  retire_valid_i,
    input logic                  retire_ready_i,
    input trace_pkg::retire_s    retire_data_i,
    input logic                  trace_valid_i,
    input logic                  trace_ready_i,
    input trace_pkg::trace_rec_s trace_data_i
);

    retire_hold: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        retire_valid_i && !retire_ready_i |=> retire_valid_i && $stable(retire_data_i))
        else $error("retire item changed or dropped while stalled");

    trace_hold: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        trace_valid_i && !trace_ready_i |=> trace_valid_i && $stable(trace_data_i))
        else $error("trace record changed or dropped while stalled");

    // The stages come out of reset empty.
    reset_empty: assert property (@(posedge s_clk_i) $rose(rst_n_i) |-> !trace_valid_i)
        else $error("trace_valid_o high right after reset release");

endmodule

bind retire_tracer retire_tracer_props u_props (
    .s_clk_i        (s_clk_i),
    .rst_n_i        (rst_n_i),
    .retire_valid_i (retire_valid_i),
    .retire_ready_i (retire_ready_o),
    .retire_data_i  (retire_i),
    .trace_valid_i  (trace_valid_o),
    .trace_ready_i  (trace_ready_i),
    .trace_data_i   (trace_o)
);

//--- design/retire_tracer.sv
// ----------------------------------------------------------------------
// Two cycles from retire accept to trace output. At most two records
// are held, after which retire_ready_o drops.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module retire_tracer (
    input  logic                  s_clk_i,
    input  logic                  rst_n_i,
    input  logic                  retire_valid_i,
    output logic                  retire_ready_o,
    input  trace_pkg::retire_s    retire_i,
    output logic                  trace_valid_o,
    input  logic                  trace_ready_i,
    output trace_pkg::trace_rec_s trace_o
);
    import trace_pkg::*;

    logic       mid_valid;
    logic       mid_ready;
    retire_s    mid_data;
    trace_rec_s mid_rec;

    trace_stage #(.payload_t(retire_s)) u_in_stage (
        .s_clk_i     (s_clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (retire_valid_i),
        .in_ready_o  (retire_ready_o),
        .in_data_i   (retire_i),
        .out_valid_o (mid_valid),
        .out_ready_i (mid_ready),
        .out_data_o  (mid_data)
    );

    instr_classify u_classify (
        .retire_i (mid_data),
        .rec_o    (mid_rec)
    );

    trace_stage #(.payload_t(trace_rec_s)) u_out_stage (
        .s_clk_i     (s_clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (mid_valid),
        .in_ready_o  (mid_ready),
        .in_data_i   (mid_rec),
        .out_valid_o (trace_valid_o),
        .out_ready_i (trace_ready_i),
        .out_data_o  (trace_o)
    );

endmodule

//--- design/instr_classify.sv
// ----------------------------------------------------------------------
// Purely combinational. The low two instruction bits pick the decoder.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module instr_classify (
    input  trace_pkg::retire_s    retire_i,
    output trace_pkg::trace_rec_s rec_o
);
    import trace_pkg::*;

    logic        rvc;
    instr_info_s rvi_info;
    instr_info_s rvc_info;

    // Full-width instructions end in 2'b11, anything else is compressed.
    assign rvc = (retire_i.instr[1:0] != 2'b11);

    rvi_decode u_rvi_decode (
        .instr_i (retire_i.instr),
        .info_o  (rvi_info)
    );

    rvc_decode u_rvc_decode (
        .instr_i (retire_i.instr[15:0]),
        .info_o  (rvc_info)
    );

    assign rec_o.retire = retire_i;
    assign rec_o.info   = rvc ? rvc_info : rvi_info;
    assign rec_o.rvc    = rvc;

endmodule

//--- design/rvc_decode.sv
// ----------------------------------------------------------------------
// Expects a 16-bit parcel from quadrants 0 to 2. Quadrant 3 and reserved
// encodings report BASE with no registers.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module rvc_decode (
    input  logic [15:0]            instr_i,
    output trace_pkg::instr_info_s info_o
);
    import trace_pkg::*;

    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd_full;
    logic [REG_AW-1:0] rs2_full;
    logic [REG_AW-1:0] creg_hi;
    logic [REG_AW-1:0] creg_lo;

    assign funct3   = instr_i[15:13];
    assign rd_full  = instr_i[11:7];
    assign rs2_full = instr_i[6:2];

    // The 3-bit register fields address x8 to x15.
    assign creg_hi = {2'b01, instr_i[9:7]};
    assign creg_lo = {2'b01, instr_i[4:2]};

    always_comb begin
        info_o.itype  = BASE;
        info_o.source = '0;
        info_o.dest   = '0;

        case (instr_i[1:0])
            2'b00: begin
                case (funct3)
                    3'd0: begin
                        info_o.source = {REG_SP, 5'd0, 1'b1, 1'b0};
                        info_o.dest   = {creg_lo, 1'b1};
                    end
                    3'd2: begin
                        info_o.itype  = LOAD;
                        info_o.source = {creg_hi, 5'd0, 1'b1, 1'b0};
                        info_o.dest   = {creg_lo, 1'b1};
                    end
                    3'd6: begin
                        // A store writes no register.
                        info_o.itype  = STORE;
                        info_o.source = {creg_hi, creg_lo, 1'b1, 1'b1};
                    end
                    default: begin
                        info_o.itype = BASE;
                    end
                endcase
            end
            2'b01: begin
                case (funct3)
                    3'd0: begin
                        info_o.source = {rd_full, 5'd0, 1'b1, 1'b0};
                        info_o.dest   = {rd_full, 1'b1};
                    end
                    3'd1: begin
                        info_o.itype = JAL;
                        info_o.dest  = {REG_RA, 1'b1};
                    end
                    3'd2: begin
                        info_o.dest = {rd_full, 1'b1};
                    end
                    3'd3: begin
                        // With rd equal to sp this is addi16sp, otherwise lui.
                        if (rd_full == REG_SP) begin
                            info_o.source = {REG_SP, 5'd0, 1'b1, 1'b0};
                            info_o.dest   = {REG_SP, 1'b1};
                        end else begin
                            info_o.dest = {rd_full, 1'b1};
                        end
                    end
                    3'd4: begin
                        info_o.source = {creg_hi, 5'd0, 1'b1, 1'b0};
                        info_o.dest   = {creg_hi, 1'b1};
                        if (instr_i[11:10] == 2'b11) begin
                            info_o.source.rs2      = creg_lo;
                            info_o.source.rs2_used = 1'b1;
                        end
                    end
                    3'd5: begin
                        info_o.itype = JAL;
                        info_o.dest  = {5'd0, 1'b1};
                    end
                    default: begin
                        info_o.itype  = BRANCH;
                        info_o.source = {creg_hi, 5'd0, 1'b1, 1'b0};
                    end
                endcase
            end
            2'b10: begin
                case (funct3)
                    3'd0: begin
                        info_o.source = {rd_full, 5'd0, 1'b1, 1'b0};
                        info_o.dest   = {rd_full, 1'b1};
                    end
                    3'd2: begin
                        info_o.itype  = LOAD;
                        info_o.source = {REG_SP, 5'd0, 1'b1, 1'b0};
                        info_o.dest   = {rd_full, 1'b1};
                    end
                    3'd4: begin
                        if (instr_i[12] && instr_i[11:2] == '0) begin
                            info_o.itype = CSR;
                        end else if (rs2_full != '0) begin
                            // c.add reads rd as rs1, c.mv does not.
                            info_o.source.rs2      = rs2_full;
                            info_o.source.rs2_used = 1'b1;
                            info_o.dest            = {rd_full, 1'b1};
                            if (instr_i[12]) begin
                                info_o.source.rs1      = rd_full;
                                info_o.source.rs1_used = 1'b1;
                            end
                        end else begin
                            info_o.itype  = JALR;
                            info_o.source = {rd_full, 5'd0, 1'b1, 1'b0};
                            info_o.dest   = {(instr_i[12] ? REG_RA : 5'd0), 1'b1};
                        end
                    end
                    3'd6: begin
                        info_o.itype  = STORE;
                        info_o.source = {REG_SP, rs2_full, 1'b1, 1'b1};
                    end
                    default: begin
                        info_o.itype = BASE;
                    end
                endcase
            end
            default: begin
                info_o.itype = BASE;
            end
        endcase
    end

endmodule

//--- design/rvi_decode.sv
// ----------------------------------------------------------------------
// Classifies by major opcode only. Illegal encodings still get a class,
// and only bit 25 of OP is looked at to tell MEXT from BASE.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module rvi_decode (
    input  logic [trace_pkg::ILEN-1:0] instr_i,
    output trace_pkg::instr_info_s     info_o
);
    import trace_pkg::*;

    logic [4:0]        opcode;
    logic [REG_AW-1:0] rs1_f;
    logic [REG_AW-1:0] rs2_f;
    logic [REG_AW-1:0] rd_f;

    assign opcode = instr_i[6:2];
    assign rs1_f  = instr_i[19:15];
    assign rs2_f  = instr_i[24:20];
    assign rd_f   = instr_i[11:7];

    always_comb begin
        // Fields that an instruction does not use stay at zero.
        info_o.itype  = BASE;
        info_o.source = '0;
        info_o.dest   = '0;

        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                info_o.dest = {rd_f, 1'b1};
            end
            OPC_JAL: begin
                info_o.itype = JAL;
                info_o.dest  = {rd_f, 1'b1};
            end
            OPC_JALR: begin
                info_o.itype           = JALR;
                info_o.source.rs1      = rs1_f;
                info_o.source.rs1_used = 1'b1;
                info_o.dest            = {rd_f, 1'b1};
            end
            OPC_BRANCH: begin
                info_o.itype  = BRANCH;
                info_o.source = {rs1_f, rs2_f, 1'b1, 1'b1};
            end
            OPC_LOAD: begin
                info_o.itype           = LOAD;
                info_o.source.rs1      = rs1_f;
                info_o.source.rs1_used = 1'b1;
                info_o.dest            = {rd_f, 1'b1};
            end
            OPC_STORE: begin
                info_o.itype  = STORE;
                info_o.source = {rs1_f, rs2_f, 1'b1, 1'b1};
            end
            OPC_OPIMM: begin
                info_o.source.rs1      = rs1_f;
                info_o.source.rs1_used = 1'b1;
                info_o.dest            = {rd_f, 1'b1};
            end
            OPC_OP: begin
                // Bit 25 marks the multiply and divide group.
                info_o.itype  = instr_i[25] ? MEXT : BASE;
                info_o.source = {rs1_f, rs2_f, 1'b1, 1'b1};
                info_o.dest   = {rd_f, 1'b1};
            end
            OPC_FENCE: begin
                info_o.itype = CSR;
            end
            OPC_SYSTEM: begin
                info_o.itype = CSR;
                // Ecall, ebreak and mret have rd and rs1 both zero.
                if (rd_f != '0 || rs1_f != '0) begin
                    info_o.dest = {rd_f, 1'b1};
                    // Bit 14 selects the immediate forms, which read no register.
                    if (!instr_i[14]) begin
                        info_o.source.rs1      = rs1_f;
                        info_o.source.rs1_used = 1'b1;
                    end
                end
            end
            default: begin
                info_o.itype = BASE;
            end
        endcase
    end

endmodule

//--- design/trace_stage.sv
// ----------------------------------------------------------------------
// One-entry valid/ready slice. in_ready_o depends combinationally on
// out_ready_i, so a chain of slices has a combinational ready path.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module trace_stage #(
    parameter type payload_t = logic
) (
    input  logic     s_clk_i,
    input  logic     rst_n_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // The slot can take a new item when it is empty or being drained.
    assign in_ready_o = ~valid_q | out_ready_i;

    always_ff @(posedge s_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

endmodule

//--- design/trace_pkg.sv
// ----------------------------------------------------------------------
// RV32 only. The pc and the instruction are both fixed at 32 bits.
// ----------------------------------------------------------------------
package trace_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int ILEN   = 32;

    // Major opcodes taken from instruction bits 6 to 2.
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_LOAD   = 5'b00000;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_OPIMM  = 5'b00100;
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_FENCE  = 5'b00011;
    localparam logic [4:0] OPC_SYSTEM = 5'b11100;

    localparam logic [REG_AW-1:0] REG_RA = 5'd1;
    localparam logic [REG_AW-1:0] REG_SP = 5'd2;

    // Fence and system instructions both report CSR.
    typedef enum logic [3:0] {
        BASE, MEXT, LOAD, STORE, BRANCH, JAL, JALR, CSR
    } itype_e;

    typedef struct packed {
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic              rs1_used;
        logic              rs2_used;
    } source_s;

    typedef struct packed {
        logic [REG_AW-1:0] rd;
        logic              rd_used;
    } dest_s;

    typedef struct packed {
        itype_e  itype;
        source_s source;
        dest_s   dest;
    } instr_info_s;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [ILEN-1:0] instr;
    } retire_s;

    typedef struct packed {
        retire_s     retire;
        instr_info_s info;
        logic        rvc;
    } trace_rec_s;

endpackage
